//--- compile.f
+incdir+testbench
common/rvPkg.sv
pipeline/ifIdReg.sv
pipeline/idRsReg.sv
pipeline/exMemReg.sv
pipeline/memWbReg.sv
src/instDecoder.sv
src/regFile.sv
src/executeUnit.sv
src/hazardUnit.sv
src/rvCore.sv
testbench/tbRvCore.sv

//--- runSim.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tbRvCore -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/VtbRvCore)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

//--- testbench/tbProgram.svh
// Core test program
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

word_t    progWords [$];
regAddr_t expRd [$];
word_t    expVal [$];
word_t    shadow [32];              // architectural register model
word_t    dmemModel [DMEM_DEPTH];
int       skipLeft;                 // slots squashed by a taken branch

// a skipped slot is fetched but changes no state
task automatic emit(word_t w, regAddr_t rd, word_t val, logic writes);
    progWords.push_back(w);
    if (skipLeft > 0) begin
        skipLeft--;
    end else if (writes && rd != 5'd0) begin
        shadow[rd] = val;
        expRd.push_back(rd);
        expVal.push_back(val);
    end
endtask

task automatic aluRR(logic [6:0] f7, logic [2:0] f3, regAddr_t rd, regAddr_t rs1,
                     regAddr_t rs2);
    word_t a;
    word_t b;
    word_t val;
    a = shadow[rs1];
    b = shadow[rs2];
    case ({f7[5], f3})
        4'b1000: val = a - b;
        4'b0111: val = a & b;
        4'b0110: val = a | b;
        4'b0100: val = a ^ b;
        4'b0010: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        default: val = a + b;
    endcase
    emit(rFormat(f7, f3, rd, rs1, rs2), rd, val, 1'b1);
endtask

task automatic addImm(regAddr_t rd, regAddr_t rs1, logic [11:0] imm);
    emit(iFormat(imm, rs1, 3'b000, rd, OP_IMM), rd, shadow[rs1] + {{20{imm[11]}}, imm}, 1'b1);
endtask

task automatic storeWord(regAddr_t rs2, regAddr_t rs1, logic [11:0] imm);
    word_t addr;
    addr = shadow[rs1] + {{20{imm[11]}}, imm};
    if (skipLeft == 0) begin
        dmemModel[addr[7:2]] = shadow[rs2];
    end
    emit(sFormat(imm, rs2, rs1), 5'd0, '0, 1'b0);
endtask

task automatic loadWord(regAddr_t rd, regAddr_t rs1, logic [11:0] imm);
    word_t addr;
    addr = shadow[rs1] + {{20{imm[11]}}, imm};
    emit(iFormat(imm, rs1, 3'b010, rd, OP_LOAD), rd, dmemModel[addr[7:2]], 1'b1);
endtask

task automatic condBranch(logic ne, regAddr_t rs1, regAddr_t rs2, int off);
    word_t offWord;
    logic  taken;
    logic  live;
    offWord = off;
    live    = (skipLeft == 0);
    taken   = ne ? (shadow[rs1] != shadow[rs2]) : (shadow[rs1] == shadow[rs2]);
    emit(bFormat(offWord[12:0], {2'b00, ne}, rs1, rs2), 5'd0, '0, 1'b0);
    if (live && taken) begin
        skipLeft = off / 4 - 1;
    end
endtask

task automatic jumpLink(regAddr_t rd, int off);
    word_t offWord;
    word_t link;
    logic  live;
    offWord = off;
    live    = (skipLeft == 0);
    link    = progWords.size() * 4 + 4;    // pc of the jal plus 4
    emit(jFormat(offWord[20:0], rd), rd, link, 1'b1);
    if (live && off > 4) begin
        skipLeft = off / 4 - 1;
    end
endtask

task automatic buildProgram();
    word_t       rnd;
    logic [11:0] immA;
    logic [11:0] immB;
    logic [11:0] immC;
    rnd  = $urandom(32'h72e0_2408);
    immA = rnd[11:0];
    rnd  = $urandom();
    immB = rnd[11:0];
    if (immB == immA) begin
        immB = immA ^ 12'h001;    // bne below must be taken
    end
    rnd  = $urandom();
    immC = rnd[11:0];
    skipLeft = 0;
    foreach (shadow[i]) begin
        shadow[i] = '0;
    end
    addImm(5'd1, 5'd0, immA);
    addImm(5'd2, 5'd0, immB);
    aluRR(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);     // add, both operands forwarded
    aluRR(7'h20, 3'b000, 5'd4, 5'd3, 5'd1);     // sub
    aluRR(7'h00, 3'b111, 5'd5, 5'd4, 5'd3);     // and
    aluRR(7'h00, 3'b110, 5'd6, 5'd5, 5'd2);     // or
    aluRR(7'h00, 3'b100, 5'd7, 5'd6, 5'd4);     // xor
    aluRR(7'h00, 3'b010, 5'd8, 5'd1, 5'd2);     // slt
    aluRR(7'h00, 3'b010, 5'd9, 5'd2, 5'd1);
    addImm(5'd10, 5'd7, immC);
    addImm(5'd0, 5'd1, 12'd5);                  // x0 write, never retires
    aluRR(7'h00, 3'b000, 5'd11, 5'd0, 5'd10);
    storeWord(5'd10, 5'd0, 12'd8);
    loadWord(5'd12, 5'd0, 12'd8);
    aluRR(7'h00, 3'b000, 5'd13, 5'd12, 5'd1);   // load-use
    condBranch(1'b0, 5'd1, 5'd1, 12);           // beq taken
    addImm(5'd14, 5'd0, 12'd1);
    addImm(5'd15, 5'd0, 12'd2);
    condBranch(1'b1, 5'd1, 5'd1, 12);           // bne falls through
    addImm(5'd14, 5'd0, 12'd3);
    condBranch(1'b1, 5'd1, 5'd2, 12);           // bne taken
    addImm(5'd16, 5'd0, 12'd4);
    addImm(5'd17, 5'd0, 12'd5);
    condBranch(1'b0, 5'd1, 5'd2, 12);           // beq falls through
    jumpLink(5'd18, 12);
    addImm(5'd19, 5'd0, 12'd6);
    addImm(5'd20, 5'd0, 12'd7);
    addImm(5'd21, 5'd18, 12'd0);
    jumpLink(5'd0, 0);                          // parks the core
endtask

`endif

//--- testbench/tbRvCore.sv
// Pipelined core testbench
`timescale 1ns/100ps
`default_nettype none

module tbRvCore import rvPkg::*; ();

    logic     clk;
    logic     reset;
    logic     run;
    logic     imemWe;
    word_t    imemAddr;
    word_t    imemWdata;
    logic     wbValid;
    regAddr_t wbRd;
    word_t    wbData;

    int retired = 0;
    int watchLimit = 0;

    function automatic word_t rFormat(logic [6:0] f7, logic [2:0] f3, regAddr_t rd,
                                      regAddr_t rs1, regAddr_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t iFormat(logic [11:0] imm, regAddr_t rs1, logic [2:0] f3,
                                      regAddr_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t sFormat(logic [11:0] imm, regAddr_t rs2, regAddr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t bFormat(logic [12:0] off, logic [2:0] f3, regAddr_t rs1,
                                      regAddr_t rs2);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t jFormat(logic [20:0] off, regAddr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    `include "tbProgram.svh"

    rvCore u_rvCore (
        .clk(clk), .reset(reset), .run(run), .imemWe(imemWe), .imemAddr(imemAddr),
        .imemWdata(imemWdata), .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // nothing may retire here
    task automatic expectIdle(string phase);
        assert (!wbValid) else begin
            $display("[FAIL] %0t ns unexpected retire of x%0d=%h %s", $time, wbRd, wbData,
                     phase);
            $display("TB FAILED");
            $fatal(1, "unexpected retirement");
        end
    endtask

    task automatic checkRetire();
        assert (wbRd == expRd[retired] && wbData == expVal[retired]) else begin
            $display("[FAIL] %0t ns record %0d expected x%0d=%h got x%0d=%h", $time,
                     retired, expRd[retired], expVal[retired], wbRd, wbData);
            $display("TB FAILED");
            $fatal(1, "retire mismatch");
        end
        retired++;
    endtask

    initial begin
        wait (watchLimit > 0);
        repeat (watchLimit) @(posedge clk);
        $display("timeout: retirement stalled after %0d of %0d records", retired,
                 expRd.size());
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset     = 1'b1;
        run       = 1'b0;
        imemWe    = 1'b0;
        imemAddr  = '0;
        imemWdata = '0;
        buildProgram();
        watchLimit = 5 + IMEM_DEPTH + 20 * progWords.size() + 50;
        for (int c = 0; c < 5; c++) begin
            @(negedge clk);
            expectIdle("during reset");
        end
        reset = 1'b0;
        // whole memory written, tail gets addr-tagged nops
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            @(negedge clk);
            expectIdle("while halted");
            imemWe    = 1'b1;
            imemAddr  = i * 4;
            imemWdata = (i < progWords.size()) ? progWords[i]
                                               : iFormat(i[11:0], 5'd0, 3'b000, 5'd0, OP_IMM);
        end
        @(negedge clk);
        expectIdle("while halted");
        imemWe = 1'b0;
        run    = 1'b1;
        while (retired < expRd.size()) begin
            @(negedge clk);
            if (wbValid) begin
                checkRetire();
            end
        end
        repeat (30) begin
            @(negedge clk);
            expectIdle("after the last record");
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/rvCore.sv
// RV32I pipelined core top level
`timescale 1ns/100ps
`default_nettype none

module rvCore import rvPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     run,
    input  logic     imemWe,
    input  word_t    imemAddr,
    input  word_t    imemWdata,
    output logic     wbValid,
    output regAddr_t wbRd,
    output word_t    wbData
);

    word_t    instMem [IMEM_DEPTH];
    word_t    dataMem [DMEM_DEPTH];
    word_t    pc, inst, idInst, idPc, idImm, rData1, rData2, loadData;
    logic     idValid, stall, flush;
    regAddr_t idRs1, idRs2, idRd;
    logic     idRegWrite, idMemRead, idMemWrite, idMemToReg, idAluSrc;
    logic     idBranch, idBranchNe, idJump;
    aluOp_t   idAluOp;

    logic     rsRegWrite, rsMemRead, rsMemWrite, rsMemToReg, rsAluSrc;
    logic     rsBranch, rsBranchNe, rsJump, rsValid;
    aluOp_t   rsAluOp;
    regAddr_t rsRs1, rsRs2, rsRd, exRd;
    word_t    rsRData1, rsRData2, rsImm, rsPc;
    fwdSel_t  fwdA, fwdB;
    word_t    aluResult, storeData, target, exAluResult, exStoreData;
    logic     redirect, exRegWrite, exMemRead, exMemWrite, exMemToReg;
    logic     liveRegWrite, liveMemRead, liveMemWrite, liveBranch, liveJump;
    logic     wbRegWrite, wbMemToReg;
    word_t    wbAluResult, wbLoadData;

    // program load only while halted
    always_ff @(posedge clk) begin
        if (imemWe && !run) begin
            instMem[imemAddr[$clog2(IMEM_DEPTH)+1:2]] <= imemWdata;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (flush) begin
            pc <= target;
        end else if (run && !stall) begin
            pc <= pc + 32'd4;
        end
    end

    assign inst = instMem[pc[$clog2(IMEM_DEPTH)+1:2]];

    ifIdReg u_ifIdReg (
        .clk(clk), .reset(reset), .stall(stall), .flush(flush),
        .inst(inst), .pc(pc), .fetchValid(run),
        .idInst(idInst), .idPc(idPc), .idValid(idValid)
    );

    instDecoder u_instDecoder (
        .inst(idInst), .rs1(idRs1), .rs2(idRs2), .rd(idRd),
        .regWrite(idRegWrite), .memRead(idMemRead), .memWrite(idMemWrite),
        .memToReg(idMemToReg), .aluSrc(idAluSrc), .aluOp(idAluOp),
        .branch(idBranch), .branchNe(idBranchNe), .jump(idJump), .imm(idImm)
    );

    regFile u_regFile (
        .clk(clk), .reset(reset), .we(wbRegWrite), .wAddr(wbRd), .wData(wbData),
        .rAddr1(idRs1), .rAddr2(idRs2), .rData1(rData1), .rData2(rData2)
    );

    idRsReg u_idRsReg (
        .clk(clk), .reset(reset), .bubble(stall || flush), .valid(idValid),
        .regWrite(idRegWrite), .memRead(idMemRead), .memWrite(idMemWrite),
        .memToReg(idMemToReg), .aluSrc(idAluSrc), .aluOp(idAluOp),
        .branch(idBranch), .branchNe(idBranchNe), .jump(idJump),
        .rs1(idRs1), .rs2(idRs2), .rd(idRd), .rData1(rData1), .rData2(rData2),
        .imm(idImm), .pc(idPc),
        .rsRegWrite(rsRegWrite), .rsMemRead(rsMemRead), .rsMemWrite(rsMemWrite),
        .rsMemToReg(rsMemToReg), .rsAluSrc(rsAluSrc), .rsAluOp(rsAluOp),
        .rsBranch(rsBranch), .rsBranchNe(rsBranchNe), .rsJump(rsJump),
        .rsRs1(rsRs1), .rsRs2(rsRs2), .rsRd(rsRd), .rsRData1(rsRData1),
        .rsRData2(rsRData2), .rsImm(rsImm), .rsPc(rsPc), .rsValid(rsValid)
    );

    // slots fetched while halted flow through without effect
    assign liveRegWrite = rsValid && rsRegWrite;
    assign liveMemRead  = rsValid && rsMemRead;
    assign liveMemWrite = rsValid && rsMemWrite;
    assign liveBranch   = rsValid && rsBranch;
    assign liveJump     = rsValid && rsJump;

    hazardUnit u_hazardUnit (
        .idRs1(idRs1), .idRs2(idRs2), .rsRs1(rsRs1), .rsRs2(rsRs2), .rsRd(rsRd),
        .rsMemRead(liveMemRead), .exRd(exRd), .exRegWrite(exRegWrite),
        .wbRd(wbRd), .wbRegWrite(wbRegWrite), .redirect(redirect),
        .fwdA(fwdA), .fwdB(fwdB), .stall(stall), .flush(flush)
    );

    executeUnit u_executeUnit (
        .aluOp(rsAluOp), .aluSrc(rsAluSrc), .fwdA(fwdA), .fwdB(fwdB),
        .rData1(rsRData1), .rData2(rsRData2), .memResult(exAluResult),
        .wbResult(wbData), .imm(rsImm), .pc(rsPc), .branch(liveBranch),
        .branchNe(rsBranchNe), .jump(liveJump), .aluResult(aluResult),
        .storeData(storeData), .redirect(redirect), .target(target)
    );

    exMemReg u_exMemReg (
        .clk(clk), .reset(reset), .regWrite(liveRegWrite), .memRead(liveMemRead),
        .memWrite(liveMemWrite), .memToReg(rsMemToReg), .rd(rsRd),
        .aluResult(aluResult), .storeData(storeData),
        .exRegWrite(exRegWrite), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
        .exMemToReg(exMemToReg), .exRd(exRd), .exAluResult(exAluResult),
        .exStoreData(exStoreData)
    );

    always_ff @(posedge clk) begin
        if (exMemWrite) begin
            dataMem[exAluResult[$clog2(DMEM_DEPTH)+1:2]] <= exStoreData;
        end
    end

    assign loadData = exMemRead ? dataMem[exAluResult[$clog2(DMEM_DEPTH)+1:2]] : '0;

    memWbReg u_memWbReg (
        .clk(clk), .reset(reset), .regWrite(exRegWrite), .memToReg(exMemToReg),
        .rd(exRd), .aluResult(exAluResult), .loadData(loadData),
        .wbRegWrite(wbRegWrite), .wbMemToReg(wbMemToReg), .wbRd(wbRd),
        .wbAluResult(wbAluResult), .wbLoadData(wbLoadData)
    );

    assign wbData  = wbMemToReg ? wbLoadData : wbAluResult;
    assign wbValid = wbRegWrite && wbRd != '0;

endmodule

`default_nettype wire

//--- src/hazardUnit.sv
// Forwarding, stall and flush control
`timescale 1ns/100ps
`default_nettype none

module hazardUnit import rvPkg::*; (
    input  regAddr_t idRs1, idRs2,
    input  regAddr_t rsRs1, rsRs2, rsRd,
    input  logic     rsMemRead,
    input  regAddr_t exRd,
    input  logic     exRegWrite,
    input  regAddr_t wbRd,
    input  logic     wbRegWrite,
    input  logic     redirect,
    output fwdSel_t  fwdA, fwdB,
    output logic     stall,
    output logic     flush
);

    logic loadUse;

    // newest producer first
    function automatic fwdSel_t pickSrc(regAddr_t src);
        if (exRegWrite && exRd != '0 && exRd == src) begin
            return FWD_MEM;
        end else if (wbRegWrite && wbRd != '0 && wbRd == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwdA = pickSrc(rsRs1);
        fwdB = pickSrc(rsRs2);
    end

    assign loadUse = rsMemRead && rsRd != '0 && (rsRd == idRs1 || rsRd == idRs2);
    assign flush   = redirect;
    assign stall   = loadUse && !redirect;    // flush wins

    // a load in issue can never be the redirecting instruction
    always_comb begin
        assert (!(flush && rsMemRead))
            else $error("flush raised with a load in issue");
    end

endmodule

`default_nettype wire

//--- src/executeUnit.sv
// Execute stage ALU and branch resolution
`timescale 1ns/100ps
`default_nettype none

module executeUnit import rvPkg::*; (
    input  aluOp_t  aluOp,
    input  logic    aluSrc,
    input  fwdSel_t fwdA, fwdB,
    input  word_t   rData1, rData2,
    input  word_t   memResult, wbResult,
    input  word_t   imm, pc,
    input  logic    branch, branchNe, jump,
    output word_t   aluResult,
    output word_t   storeData,
    output logic    redirect,
    output word_t   target
);

    word_t opA, opB;

    function automatic word_t fwdMux(fwdSel_t sel, word_t regVal);
        case (sel)
            FWD_MEM: return memResult;
            FWD_WB:  return wbResult;
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        opA       = fwdMux(fwdA, rData1);
        storeData = fwdMux(fwdB, rData2);
        opB       = jump ? pc + 32'd4 : (aluSrc ? imm : storeData);    // link value for jal
        case (aluOp)
            ALU_SUB:  aluResult = opA - opB;
            ALU_AND:  aluResult = opA & opB;
            ALU_OR:   aluResult = opA | opB;
            ALU_XOR:  aluResult = opA ^ opB;
            ALU_SLT:  aluResult = {31'b0, $signed(opA) < $signed(opB)};
            ALU_PASSB: aluResult = opB;
            default:  aluResult = opA + opB;
        endcase
    end

    // branches compare the forwarded rs2, never the immediate
    assign target   = pc + imm;
    assign redirect = jump || (branch && ((opA == storeData) != branchNe));

endmodule

`default_nettype wire

//--- src/regFile.sv
// Integer register file
`timescale 1ns/100ps
`default_nettype none

module regFile import rvPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     we,
    input  regAddr_t wAddr,
    input  word_t    wData,
    input  regAddr_t rAddr1, rAddr2,
    output word_t    rData1, rData2
);

    word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

    // write-through so writeback and decode can share a cycle
    assign rData1 = (rAddr1 == '0) ? '0 : (we && wAddr == rAddr1) ? wData : regs[rAddr1];
    assign rData2 = (rAddr2 == '0) ? '0 : (we && wAddr == rAddr2) ? wData : regs[rAddr2];

endmodule

`default_nettype wire

//--- src/instDecoder.sv
// RV32I instruction decoder
`timescale 1ns/100ps
`default_nettype none

module instDecoder import rvPkg::*; (
    input  word_t    inst,
    output regAddr_t rs1, rs2, rd,
    output logic     regWrite, memRead, memWrite, memToReg, aluSrc,
    output aluOp_t   aluOp,
    output logic     branch, branchNe, jump,
    output word_t    imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    always_comb begin
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        aluSrc   = 1'b0;
        aluOp    = ALU_ADD;
        branch   = 1'b0;
        branchNe = funct3[0];
        jump     = 1'b0;
        imm      = {{20{inst[31]}}, inst[31:20]};    // I-type
        case (opcode)
            OP_REG: begin
                regWrite = 1'b1;
                case (funct3)
                    3'b000:  aluOp = inst[30] ? ALU_SUB : ALU_ADD;
                    3'b111:  aluOp = ALU_AND;
                    3'b110:  aluOp = ALU_OR;
                    3'b100:  aluOp = ALU_XOR;
                    3'b010:  aluOp = ALU_SLT;
                    default: regWrite = 1'b0;
                endcase
            end
            OP_IMM: begin
                regWrite = (funct3 == 3'b000);    // addi only
                aluSrc   = 1'b1;
            end
            OP_LOAD: begin
                regWrite = (funct3 == 3'b010);
                memRead  = (funct3 == 3'b010);
                memToReg = 1'b1;
                aluSrc   = 1'b1;
            end
            OP_STORE: begin
                memWrite = (funct3 == 3'b010);
                aluSrc   = 1'b1;
                imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            OP_BRANCH: begin
                branch = (funct3[2:1] == 2'b00);    // beq, bne
                imm    = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            OP_JAL: begin
                regWrite = 1'b1;
                jump     = 1'b1;
                aluOp    = ALU_PASSB;
                imm      = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                            inst[30:21], 1'b0};
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- pipeline/memWbReg.sv
// Memory to writeback register
`timescale 1ns/100ps
`default_nettype none

module memWbReg import rvPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     regWrite, memToReg,
    input  regAddr_t rd,
    input  word_t    aluResult, loadData,
    output logic     wbRegWrite, wbMemToReg,
    output regAddr_t wbRd,
    output word_t    wbAluResult, wbLoadData
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wbRegWrite <= 1'b0;
            wbMemToReg <= 1'b0;
        end else begin
            wbRegWrite <= regWrite;
            wbMemToReg <= memToReg;
        end
    end

    always_ff @(posedge clk) begin
        wbRd        <= rd;
        wbAluResult <= aluResult;
        wbLoadData  <= loadData;
    end

endmodule

`default_nettype wire

//--- pipeline/exMemReg.sv
// Execute to memory register
`timescale 1ns/100ps
`default_nettype none

module exMemReg import rvPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     regWrite, memRead, memWrite, memToReg,
    input  regAddr_t rd,
    input  word_t    aluResult,
    input  word_t    storeData,
    output logic     exRegWrite, exMemRead, exMemWrite, exMemToReg,
    output regAddr_t exRd,
    output word_t    exAluResult,
    output word_t    exStoreData
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exMemToReg <= 1'b0;
        end else begin
            exRegWrite <= regWrite;
            exMemRead  <= memRead;
            exMemWrite <= memWrite;
            exMemToReg <= memToReg;
        end
    end

    always_ff @(posedge clk) begin
        exRd        <= rd;
        exAluResult <= aluResult;    // also the data address
        exStoreData <= storeData;
    end

endmodule

`default_nettype wire

//--- pipeline/idRsReg.sv
// Decode to issue register
`timescale 1ns/100ps
`default_nettype none

module idRsReg import rvPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     bubble,
    input  logic     valid,
    input  logic     regWrite, memRead, memWrite, memToReg, aluSrc,
    input  aluOp_t   aluOp,
    input  logic     branch, branchNe, jump,
    input  regAddr_t rs1, rs2, rd,
    input  word_t    rData1, rData2, imm, pc,
    output logic     rsRegWrite, rsMemRead, rsMemWrite, rsMemToReg, rsAluSrc,
    output aluOp_t   rsAluOp,
    output logic     rsBranch, rsBranchNe, rsJump,
    output regAddr_t rsRs1, rsRs2, rsRd,
    output word_t    rsRData1, rsRData2, rsImm, rsPc,
    output logic     rsValid
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset || bubble) begin
            rsRegWrite <= 1'b0;
            rsMemRead  <= 1'b0;
            rsMemWrite <= 1'b0;
            rsMemToReg <= 1'b0;
            rsBranch   <= 1'b0;
            rsJump     <= 1'b0;
            rsValid    <= 1'b0;
        end else begin
            rsRegWrite <= regWrite;
            rsMemRead  <= memRead;
            rsMemWrite <= memWrite;
            rsMemToReg <= memToReg;
            rsBranch   <= branch;
            rsJump     <= jump;
            rsValid    <= valid;
        end
    end

    // operands and selects, only meaningful with the control above
    always_ff @(posedge clk) begin
        rsAluSrc   <= aluSrc;
        rsAluOp    <= aluOp;
        rsBranchNe <= branchNe;
        rsRs1      <= rs1;
        rsRs2      <= rs2;
        rsRd       <= rd;
        rsRData1   <= rData1;
        rsRData2   <= rData2;
        rsImm      <= imm;
        rsPc       <= pc;
    end

    assert property (@(posedge clk) disable iff (reset) !(memRead && memWrite));

endmodule

`default_nettype wire

//--- pipeline/ifIdReg.sv
// Fetch to decode register
`timescale 1ns/100ps
`default_nettype none

module ifIdReg import rvPkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  stall,
    input  logic  flush,
    input  word_t inst,
    input  word_t pc,
    input  logic  fetchValid,
    output word_t idInst,
    output word_t idPc,
    output logic  idValid
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idInst  <= NOP_INST;
            idPc    <= '0;
            idValid <= 1'b0;
        end else if (flush) begin
            idInst  <= NOP_INST;    // squashed slot
            idValid <= 1'b0;
        end else if (!stall) begin
            idInst  <= inst;
            idPc    <= pc;
            idValid <= fetchValid;
        end
    end

    // a load-use stall clears once the load leaves issue, a flush bubbles execute
    assert property (@(posedge clk) disable iff (reset) stall |=> !stall);
    assert property (@(posedge clk) disable iff (reset) flush |=> !flush);

endmodule

`default_nettype wire

//--- common/rvPkg.sv
// RV32I core shared definitions
`default_nettype none

package rvPkg;

    typedef logic [31:0] word_t;    // data, address or instruction
    typedef logic [4:0]  regAddr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASSB
    } aluOp_t;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwdSel_t;

    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;

    localparam word_t NOP_INST = 32'h0000_0013;    // addi x0, x0, 0

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

endpackage

`default_nettype wire
